// ==== hdl/csr_bank.sv ====
`timescale 1ns/1ps

module csr_bank
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      csr_we,
    input  csr_addr_t csr_waddr,
    input  word_t     csr_wdata,
    input  csr_addr_t csr_raddr,
    output word_t     csr_rdata
);

    word_t mstatus;
    word_t mtvec;
    word_t mepc;
    word_t mcause;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (csr_we) begin
            case (csr_waddr)
                csr_mstatus: mstatus <= csr_wdata;
                csr_mtvec:   mtvec   <= csr_wdata;
                csr_mepc:    mepc    <= csr_wdata;
                csr_mcause:  mcause  <= csr_wdata;
                default:     ;  // unimplemented CSRs drop the write.
            endcase
        end
    end

    always_comb begin
        case (csr_raddr)
            csr_mstatus: csr_rdata = mstatus;
            csr_mtvec:   csr_rdata = mtvec;
            csr_mepc:    csr_rdata = mepc;
            csr_mcause:  csr_rdata = mcause;
            default:     csr_rdata = '0;
        endcase
    end

endmodule

// ==== hdl/decode_control.sv ====
`timescale 1ns/1ps

module decode_control
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      inst_req,
    input  word_t     inst,
    input  word_t     inst_pc,
    output logic      inst_ack,
    output word_t     slot_inst,
    output logic      dec_req,
    input  logic      dec_ack,
    input  op_t       next_op,
    input  word_t     next_immed,
    input  word_t     next_reg1_value,
    input  word_t     next_reg2_value,
    input  word_t     next_csr_value,
    output op_t       dec_op,
    output word_t     dec_immed,
    output reg_addr_t dec_reg1_addr,
    output reg_addr_t dec_reg2_addr,
    output word_t     dec_reg1_value,
    output word_t     dec_reg2_value,
    output word_t     dec_csr_value,
    output word_t     dec_inst,
    output word_t     dec_pc
);

    logic  in_valid;  // input slot holds an instruction not yet moved on.
    logic  out_full;  // output slot busy until its handshake has completed.
    word_t slot_pc;
    logic  capture;
    logic  transfer;

    // the input slot is free only when the previous ack has dropped again.
    assign capture  = inst_req && !inst_ack && !in_valid;
    assign transfer = in_valid && !out_full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst_ack <= 1'b0;
            in_valid <= 1'b0;
        end else begin
            if (capture) begin
                inst_ack <= 1'b1;
                in_valid <= 1'b1;
            end else begin
                if (inst_ack && !inst_req) begin
                    inst_ack <= 1'b0;
                end
                if (transfer) begin
                    in_valid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_req  <= 1'b0;
            out_full <= 1'b0;
        end else begin
            if (transfer) begin
                dec_req  <= 1'b1;
                out_full <= 1'b1;
            end else if (dec_req && dec_ack) begin
                dec_req <= 1'b0;
            end else if (out_full && !dec_req && !dec_ack) begin
                out_full <= 1'b0;  // downstream has released the record.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            slot_inst <= inst;
            slot_pc   <= inst_pc;
        end
        if (transfer) begin
            dec_op         <= next_op;
            dec_immed      <= next_immed;
            dec_reg1_value <= next_reg1_value;  // forwarding sampled here.
            dec_reg2_value <= next_reg2_value;
            dec_csr_value  <= next_csr_value;
            dec_inst       <= slot_inst;
            dec_pc         <= slot_pc;
        end
    end

    assign dec_reg1_addr = dec_inst[19:15];
    assign dec_reg2_addr = dec_inst[24:20];

    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(inst_ack) |-> $past(inst_req));

    assert property (@(posedge clk) disable iff (!arst_n)
        $fell(dec_req) |-> $past(dec_ack));

    assert property (@(posedge clk) disable iff (!arst_n)
        dec_req && $past(dec_req) |-> $stable({dec_op, dec_immed, dec_reg1_value,
            dec_reg2_value, dec_csr_value, dec_inst, dec_pc}));

endmodule

// ==== hdl/decode_pkg.sv ====
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;

    // operation class of a decoded instruction.
    typedef enum logic [3:0] {
        op_alu_reg,
        op_alu_imm,
        op_load,
        op_store,
        op_branch,
        op_jal,
        op_jalr,
        op_lui,
        op_auipc,
        op_system,
        op_illegal
    } op_t;

    // machine CSR addresses held by the CSR bank.
    localparam csr_addr_t csr_mstatus = 12'h300;
    localparam csr_addr_t csr_mtvec   = 12'h305;
    localparam csr_addr_t csr_mepc    = 12'h341;
    localparam csr_addr_t csr_mcause  = 12'h342;

endpackage

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
    import decode_pkg::*;
#(
    parameter int reg_count = 32
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      inst_req,
    input  word_t     inst,
    input  word_t     inst_pc,
    output logic      inst_ack,
    output logic      dec_req,
    output op_t       dec_op,
    output word_t     dec_immed,
    output reg_addr_t dec_reg1_addr,
    output reg_addr_t dec_reg2_addr,
    output word_t     dec_reg1_value,
    output word_t     dec_reg2_value,
    output word_t     dec_csr_value,
    output word_t     dec_inst,
    output word_t     dec_pc,
    input  logic      dec_ack,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    input  logic      csr_we,
    input  csr_addr_t csr_waddr,
    input  word_t     csr_wdata,
    input  logic      fwd1_en,
    input  reg_addr_t fwd1_addr,
    input  word_t     fwd1_data,
    input  logic      fwd2_en,
    input  reg_addr_t fwd2_addr,
    input  word_t     fwd2_data,
    input  logic      fwd3_en,
    input  reg_addr_t fwd3_addr,
    input  word_t     fwd3_data
);

    word_t slot_inst;
    op_t   next_op;
    word_t next_immed;
    word_t rd1_data;
    word_t rd2_data;
    word_t next_reg1_value;
    word_t next_reg2_value;
    word_t next_csr_value;

    decode_control decode_control_i (
        .clk(clk), .arst_n(arst_n),
        .inst_req(inst_req), .inst(inst), .inst_pc(inst_pc), .inst_ack(inst_ack),
        .slot_inst(slot_inst),
        .dec_req(dec_req), .dec_ack(dec_ack),
        .next_op(next_op), .next_immed(next_immed),
        .next_reg1_value(next_reg1_value), .next_reg2_value(next_reg2_value),
        .next_csr_value(next_csr_value),
        .dec_op(dec_op), .dec_immed(dec_immed),
        .dec_reg1_addr(dec_reg1_addr), .dec_reg2_addr(dec_reg2_addr),
        .dec_reg1_value(dec_reg1_value), .dec_reg2_value(dec_reg2_value),
        .dec_csr_value(dec_csr_value), .dec_inst(dec_inst), .dec_pc(dec_pc)
    );

    inst_classifier inst_classifier_i (.inst(slot_inst), .op(next_op));

    immed_extractor immed_extractor_i (.inst(slot_inst), .op(next_op), .immed(next_immed));

    reg_file #(.reg_count(reg_count)) reg_file_i (
        .clk(clk), .arst_n(arst_n),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .rd1_addr(slot_inst[19:15]), .rd2_addr(slot_inst[24:20]),
        .rd1_data(rd1_data), .rd2_data(rd2_data)
    );

    operand_forwarder forward1_i (
        .src_addr(slot_inst[19:15]),
        .fwd1_en(fwd1_en), .fwd1_addr(fwd1_addr), .fwd1_data(fwd1_data),
        .fwd2_en(fwd2_en), .fwd2_addr(fwd2_addr), .fwd2_data(fwd2_data),
        .fwd3_en(fwd3_en), .fwd3_addr(fwd3_addr), .fwd3_data(fwd3_data),
        .reg_value(rd1_data), .value(next_reg1_value)
    );

    operand_forwarder forward2_i (
        .src_addr(slot_inst[24:20]),
        .fwd1_en(fwd1_en), .fwd1_addr(fwd1_addr), .fwd1_data(fwd1_data),
        .fwd2_en(fwd2_en), .fwd2_addr(fwd2_addr), .fwd2_data(fwd2_data),
        .fwd3_en(fwd3_en), .fwd3_addr(fwd3_addr), .fwd3_data(fwd3_data),
        .reg_value(rd2_data), .value(next_reg2_value)
    );

    csr_bank csr_bank_i (
        .clk(clk), .arst_n(arst_n),
        .csr_we(csr_we), .csr_waddr(csr_waddr), .csr_wdata(csr_wdata),
        .csr_raddr(slot_inst[31:20]), .csr_rdata(next_csr_value)
    );

endmodule

// ==== hdl/immed_extractor.sv ====
`timescale 1ns/1ps

module immed_extractor
    import decode_pkg::*;
(
    input  word_t inst,
    input  op_t   op,
    output word_t immed
);

    always_comb begin
        case (op)
            op_alu_imm, op_load, op_jalr, op_system: begin
                immed = {{20{inst[31]}}, inst[31:20]};
            end
            op_store: begin
                immed = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            op_branch: begin
                // branch offsets are in halfwords, so bit zero is always clear.
                immed = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            op_lui, op_auipc: begin
                immed = {inst[31:12], 12'h000};
            end
            op_jal: begin
                immed = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21],
                         1'b0};
            end
            default: begin
                immed = '0;  // register ops and illegal opcodes carry no immediate.
            end
        endcase
    end

endmodule

// ==== hdl/inst_classifier.sv ====
`timescale 1ns/1ps

module inst_classifier
    import decode_pkg::*;
(
    input  word_t inst,
    output op_t   op
);

    logic [4:0] opcode_hi;

    assign opcode_hi = inst[6:2];

    // 32-bit encodings all end in 11, anything else is compressed or garbage.
    always_comb begin
        if (inst[1:0] != 2'b11) begin
            op = op_illegal;
        end else begin
            case (opcode_hi)
                5'b01100: begin
                    op = op_alu_reg;
                end
                5'b00100: begin
                    op = op_alu_imm;
                end
                5'b00000: begin
                    op = op_load;
                end
                5'b01000: begin
                    op = op_store;
                end
                5'b11000: begin
                    op = op_branch;
                end
                5'b11011: begin
                    op = op_jal;
                end
                5'b11001: begin
                    op = op_jalr;
                end
                5'b01101: begin
                    op = op_lui;
                end
                5'b00101: begin
                    op = op_auipc;
                end
                5'b11100: begin
                    op = op_system;  // includes the csr instructions.
                end
                default: begin
                    op = op_illegal;
                end
            endcase
        end
    end

endmodule

// ==== hdl/operand_forwarder.sv ====
`timescale 1ns/1ps

module operand_forwarder
    import decode_pkg::*;
(
    input  reg_addr_t src_addr,
    input  logic      fwd1_en,
    input  reg_addr_t fwd1_addr,
    input  word_t     fwd1_data,
    input  logic      fwd2_en,
    input  reg_addr_t fwd2_addr,
    input  word_t     fwd2_data,
    input  logic      fwd3_en,
    input  reg_addr_t fwd3_addr,
    input  word_t     fwd3_data,
    input  word_t     reg_value,
    output word_t     value
);

    logic src_nonzero;

    assign src_nonzero = (src_addr != '0);  // x0 is never forwarded.

    always_comb begin
        if (src_nonzero && fwd1_en && fwd1_addr == src_addr) begin
            value = fwd1_data;
        end else if (src_nonzero && fwd2_en && fwd2_addr == src_addr) begin
            value = fwd2_data;
        end else if (src_nonzero && fwd3_en && fwd3_addr == src_addr) begin
            value = fwd3_data;
        end else begin
            value = reg_value;
        end
    end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import decode_pkg::*;
#(
    parameter int reg_count = 32
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    input  reg_addr_t rd1_addr,
    input  reg_addr_t rd2_addr,
    output word_t     rd1_data,
    output word_t     rd2_data
);

    word_t regs [1:reg_count-1];  // x0 has no storage.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0 && wb_addr < reg_count) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // addresses past the implemented registers read as zero.
    assign rd1_data = (rd1_addr != '0 && rd1_addr < reg_count) ? regs[rd1_addr] : '0;
    assign rd2_data = (rd2_addr != '0 && rd2_addr < reg_count) ? regs[rd2_addr] : '0;

    // written data reads back one cycle later while x0 and unimplemented addresses stay zero.
    assert property (@(posedge clk) disable iff (!arst_n)
        $past(arst_n && wb_en) && rd1_addr == $past(wb_addr)
            |-> rd1_data == (($past(wb_addr) == '0 || $past(wb_addr) >= reg_count) ?
                '0 : $past(wb_data)));

endmodule

// ==== list.f ====
hdl/decode_pkg.sv
hdl/decode_control.sv
hdl/inst_classifier.sv
hdl/immed_extractor.sv
hdl/operand_forwarder.sv
hdl/reg_file.sv
hdl/csr_bank.sv
hdl/decode_stage.sv
testbench/decode_stage_tb.sv

// ==== testbench/decode_stage_tb.sv ====
`timescale 1ns/1ps

module decode_stage_tb
    import decode_pkg::*;
();

    localparam int inst_total  = 200;
    localparam int cycle_limit = 5000;  // 200 instructions at 20 cycles, reset and margin.

    typedef struct packed {
        op_t       op;
        word_t     immed;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     reg1;
        word_t     reg2;
        word_t     csr;
        word_t     inst;
        word_t     pc;
    } expect_t;

    logic      clk;
    logic      arst_n;
    logic      inst_req;
    word_t     inst;
    word_t     inst_pc;
    logic      inst_ack;
    logic      dec_req;
    op_t       dec_op;
    word_t     dec_immed;
    reg_addr_t dec_reg1_addr;
    reg_addr_t dec_reg2_addr;
    word_t     dec_reg1_value;
    word_t     dec_reg2_value;
    word_t     dec_csr_value;
    word_t     dec_inst;
    word_t     dec_pc;
    logic      dec_ack;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      csr_we;
    csr_addr_t csr_waddr;
    word_t     csr_wdata;
    logic      fwd1_en;
    reg_addr_t fwd1_addr;
    word_t     fwd1_data;
    logic      fwd2_en;
    reg_addr_t fwd2_addr;
    word_t     fwd2_data;
    logic      fwd3_en;
    reg_addr_t fwd3_addr;
    word_t     fwd3_data;

    word_t      reg_m [32];
    word_t      csr_m [4];
    logic       f_en [3];
    reg_addr_t  f_addr [3];
    word_t      f_data [3];
    expect_t    exp_q [$];
    string      name_q [$];
    int         sent_count = 0;
    int         overlap_count = 0;
    int         cycles = 0;
    word_t      next_pc;
    logic       prev_dec_req = 1'b0;
    logic       prev_inst_ack = 1'b0;
    logic [6:0] legal_opcodes [10] = '{7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011,
        7'b1100011, 7'b1101111, 7'b1100111, 7'b0110111, 7'b0010111, 7'b1110011};
    csr_addr_t  csr_targets [5] = '{csr_mstatus, csr_mtvec, csr_mepc, csr_mcause, 12'h7c0};

    decode_stage #(.reg_count(32)) decode_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $fatal(1);
        end
    end

    function automatic int csr_index(csr_addr_t a);
        case (a)
            csr_mstatus: return 0;
            csr_mtvec:   return 1;
            csr_mepc:    return 2;
            csr_mcause:  return 3;
            default:     return -1;
        endcase
    endfunction

    // lowest numbered enabled port wins, x0 is never forwarded.
    function automatic word_t operand_ref(reg_addr_t a);
        if (a != '0) begin
            for (int i = 0; i < 3; i++) begin
                if (f_en[i] && f_addr[i] == a) begin
                    return f_data[i];
                end
            end
        end
        return reg_m[a];
    endfunction

    function automatic expect_t decode_ref(word_t w, word_t pc);
        expect_t e;
        word_t   t;
        int      idx;
        case (w[6:0])
            7'b0110011: e.op = op_alu_reg;
            7'b0010011: e.op = op_alu_imm;
            7'b0000011: e.op = op_load;
            7'b0100011: e.op = op_store;
            7'b1100011: e.op = op_branch;
            7'b1101111: e.op = op_jal;
            7'b1100111: e.op = op_jalr;
            7'b0110111: e.op = op_lui;
            7'b0010111: e.op = op_auipc;
            7'b1110011: e.op = op_system;
            default:    e.op = op_illegal;
        endcase
        // each format packs its fields at the top, then shifts down arithmetically.
        case (e.op)
            op_alu_imm, op_load, op_jalr, op_system: e.immed = $signed(w) >>> 20;
            op_store: begin
                t = {w[31:25], w[11:7], 20'h0};
                e.immed = $signed(t) >>> 20;
            end
            op_branch: begin
                t = {w[31], w[7], w[30:25], w[11:8], 20'h0};
                e.immed = $signed(t) >>> 19;
            end
            op_lui, op_auipc: e.immed = {w[31:12], 12'h0};
            op_jal: begin
                t = {w[31], w[19:12], w[20], w[30:21], 12'h0};
                e.immed = $signed(t) >>> 11;
            end
            default: e.immed = '0;
        endcase
        e.rs1  = w[19:15];
        e.rs2  = w[24:20];
        e.reg1 = operand_ref(e.rs1);
        e.reg2 = operand_ref(e.rs2);
        idx    = csr_index(w[31:20]);
        e.csr  = (idx < 0) ? '0 : csr_m[idx];
        e.inst = w;
        e.pc   = pc;
        return e;
    endfunction

    function automatic word_t make_inst();
        word_t w;
        int    sel;
        w   = $urandom;
        sel = $urandom_range(0, 10);
        if (sel < 10) begin
            w[6:0] = legal_opcodes[sel];  // sel 10 keeps a random, mostly illegal opcode.
        end
        if ($urandom_range(0, 1) == 1) begin
            w[19:15] = 5'($urandom_range(0, 7));  // small numbers make forwarding hits likely.
            w[24:20] = 5'($urandom_range(0, 7));
        end
        return w;
    endfunction

    function automatic word_t system_inst(csr_addr_t a, reg_addr_t rs1);
        return {a, rs1, 3'b010, 5'd3, 7'b1110011};
    endfunction

    task automatic report_mismatch(string test, string field, word_t expected, word_t actual);
        $display("FAIL %s %s: expected %h, actual %h", test, field, expected, actual);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic send_inst(string name, word_t w);
        exp_q.push_back(decode_ref(w, next_pc));
        name_q.push_back(name);
        @(posedge clk);
        inst_req <= 1'b1;
        inst     <= w;
        inst_pc  <= next_pc;
        next_pc    = next_pc + 4;
        sent_count = sent_count + 1;
        do begin
            @(posedge clk);
        end while (!inst_ack);
        inst_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (inst_ack);
    endtask

    // both slots are empty once every record was offered and both handshakes are idle.
    task automatic wait_idle();
        do begin
            @(posedge clk);
        end while (exp_q.size() != 0 || inst_req || inst_ack || dec_req || dec_ack);
    endtask

    task automatic write_reg(reg_addr_t a, word_t d);
        @(posedge clk);
        wb_en   <= 1'b1;
        wb_addr <= a;
        wb_data <= d;
        @(posedge clk);
        wb_en <= 1'b0;
        if (a != '0) begin
            reg_m[a] = d;
        end
    endtask

    task automatic write_csr(csr_addr_t a, word_t d);
        int idx;
        idx = csr_index(a);
        @(posedge clk);
        csr_we    <= 1'b1;
        csr_waddr <= a;
        csr_wdata <= d;
        @(posedge clk);
        csr_we <= 1'b0;
        if (idx >= 0) begin
            csr_m[idx] = d;
        end
    endtask

    task automatic set_forwarding(bit enable);
        for (int i = 0; i < 3; i++) begin
            f_en[i]   = enable && ($urandom_range(0, 1) == 1);
            f_addr[i] = 5'($urandom_range(0, 7));
            f_data[i] = $urandom;
        end
        @(posedge clk);
        fwd1_en   <= f_en[0];
        fwd1_addr <= f_addr[0];
        fwd1_data <= f_data[0];
        fwd2_en   <= f_en[1];
        fwd2_addr <= f_addr[1];
        fwd2_data <= f_data[1];
        fwd3_en   <= f_en[2];
        fwd3_addr <= f_addr[2];
        fwd3_data <= f_data[2];
    endtask

    // downstream acknowledges each record after 0 to 5 cycles.
    initial begin
        int delay;
        forever begin
            @(posedge clk);
            if (dec_req && !dec_ack) begin
                delay = $urandom_range(0, 5);
                repeat (delay) @(posedge clk);
                dec_ack <= 1'b1;
            end else if (!dec_req && dec_ack) begin
                dec_ack <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        expect_t e;
        string   name;
        if (dec_req && !prev_dec_req) begin
            if (exp_q.size() == 0) begin
                $display("a decoded record was offered with no instruction outstanding");
                $display("Test failed");
                $fatal(1);
            end else begin
                e    = exp_q.pop_front();
                name = name_q.pop_front();
                assert (dec_inst === e.inst) else report_mismatch(name, "inst", e.inst, dec_inst);
                assert (dec_pc === e.pc) else report_mismatch(name, "pc", e.pc, dec_pc);
                assert (dec_op === e.op)
                    else report_mismatch(name, "op", word_t'(e.op), word_t'(dec_op));
                assert (dec_immed === e.immed)
                    else report_mismatch(name, "immed", e.immed, dec_immed);
                assert (dec_reg1_addr === e.rs1)
                    else report_mismatch(name, "reg1_addr", e.rs1, dec_reg1_addr);
                assert (dec_reg2_addr === e.rs2)
                    else report_mismatch(name, "reg2_addr", e.rs2, dec_reg2_addr);
                assert (dec_reg1_value === e.reg1)
                    else report_mismatch(name, "reg1_value", e.reg1, dec_reg1_value);
                assert (dec_reg2_value === e.reg2)
                    else report_mismatch(name, "reg2_value", e.reg2, dec_reg2_value);
                assert (dec_csr_value === e.csr)
                    else report_mismatch(name, "csr_value", e.csr, dec_csr_value);
            end
        end
        if (inst_ack && !prev_inst_ack && dec_req) begin
            overlap_count = overlap_count + 1;  // captured while the output slot still offers.
        end
        prev_dec_req  <= dec_req;
        prev_inst_ack <= inst_ack;
    end

    initial begin
        int size;
        void'($urandom(32'h2df8383c));
        arst_n    = 1'b0;
        inst_req  = 1'b0;
        inst      = '0;
        inst_pc   = '0;
        dec_ack   = 1'b0;
        wb_en     = 1'b0;
        wb_addr   = '0;
        wb_data   = '0;
        csr_we    = 1'b0;
        csr_waddr = '0;
        csr_wdata = '0;
        fwd1_en   = 1'b0;
        fwd1_addr = '0;
        fwd1_data = '0;
        fwd2_en   = 1'b0;
        fwd2_addr = '0;
        fwd2_data = '0;
        fwd3_en   = 1'b0;
        fwd3_addr = '0;
        fwd3_data = '0;
        for (int i = 0; i < 32; i++) begin
            reg_m[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            csr_m[i] = '0;
        end
        for (int i = 0; i < 3; i++) begin
            f_en[i]   = 1'b0;
            f_addr[i] = '0;
            f_data[i] = '0;
        end
        next_pc = 32'h0000_1000;
        repeat (10) begin
            @(negedge clk);
            assert (!inst_ack && !dec_req) else begin
                $display("inst_ack or dec_req was high during reset");
                $display("Test failed");
                $fatal(1);
            end
        end
        @(posedge clk);
        arst_n <= 1'b1;

        // nothing written yet, so operands and the CSR read back as zero.
        send_inst("reset_state", system_inst(csr_mepc, 5'd7));
        wait_idle();

        foreach (csr_targets[i]) begin
            write_csr(csr_targets[i], $urandom);
        end
        foreach (csr_targets[i]) begin
            send_inst("csr_bank", system_inst(csr_targets[i], 5'd0));
        end
        wait_idle();

        write_reg(5'd0, 32'hffff_ffff);
        write_reg(5'd5, $urandom);
        send_inst("register_zero", {7'h00, 5'd5, 5'd0, 3'b000, 5'd1, 7'b0110011});
        wait_idle();

        // groups are offered back to back while downstream holds off its ack.
        while (sent_count < inst_total) begin
            set_forwarding(1'b1);
            repeat ($urandom_range(0, 3)) write_reg(5'($urandom), $urandom);
            if ($urandom_range(0, 3) == 0) begin
                write_csr(csr_targets[$urandom_range(0, 4)], $urandom);
            end
            size = $urandom_range(1, 4);
            for (int j = 0; j < size && sent_count < inst_total; j++) begin
                send_inst("random_decode", make_inst());
            end
            wait_idle();
        end

        if (overlap_count > 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("FAIL in_flight: expected at least 1 overlapped capture, actual %0d",
                overlap_count);
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule
